//--- blocking_crossbar.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module blocking_crossbar (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        in_val   [2],
  output logic                        in_rdy   [2],
  input  logic [`DATA_W-1:0]          in_data  [2],
  output logic                        out_val  [2],
  input  logic                        out_rdy  [2],
  output logic [`DATA_W-1:0]          out_data [2],
  input  logic                        ctl_val,
  output logic                        ctl_rdy,
  input  interconnect_pkg::xbar_cfg_t ctl_cfg
);
  import interconnect_pkg::*;

  xbar_cfg_t route_q;
  logic      data_xfer;

  // ==============================
  // data path, one route at a time
  // ==============================
  always_comb begin
    for (int o = 0; o < 2; o++) begin
      out_val[o]  = (route_q.out_sel == 1'(o)) && in_val[route_q.in_sel];
      out_data[o] = in_data[route_q.in_sel];
    end
    // unrouted inputs stall
    for (int i = 0; i < 2; i++) begin
      in_rdy[i] = (route_q.in_sel == 1'(i)) && out_rdy[route_q.out_sel];
    end
  end

  assign data_xfer = in_val[route_q.in_sel] & out_rdy[route_q.out_sel];

  // ==============================
  // route register
  // ==============================

  // hold off reconfig while data moves
  assign ctl_rdy = ~data_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= '{in_sel: 1'b0, out_sel: 1'b0};
    end else if (ctl_val && ctl_rdy) begin
      route_q <= ctl_cfg;
    end
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+.
interconnect_pkg.sv
spi_minion.sv
packet_router.sv
stream_arbiter.sv
blocking_crossbar.sv
sample_deserializer.sv
sample_serializer.sv
hadamard_transform.sv
interconnect_top.sv
tb_clock_gen.sv
interconnect_tb.sv

//--- hadamard_transform.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module hadamard_transform (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_val,
  output logic               in_rdy,
  input  logic [`DATA_W-1:0] in_block  [`N_SAMPLES],
  output logic               out_val,
  input  logic               out_rdy,
  output logic [`DATA_W-1:0] out_block [`N_SAMPLES]
);

  logic               full_q;
  logic [`DATA_W-1:0] y [`N_SAMPLES];
  logic [`DATA_W-1:0] y_q [`N_SAMPLES];

  // butterflies, all sums wrap at data width
  always_comb begin
    y[0] = in_block[0] + in_block[1] + in_block[2] + in_block[3];
    y[1] = in_block[0] - in_block[1] + in_block[2] - in_block[3];
    y[2] = in_block[0] + in_block[1] - in_block[2] - in_block[3];
    y[3] = in_block[0] - in_block[1] - in_block[2] + in_block[3];
  end

  // stage empty or emptying
  assign in_rdy = ~full_q | out_rdy;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      full_q <= 1'b1;
    end else if (out_rdy) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      y_q <= y;
    end
  end

  assign out_val   = full_q;
  assign out_block = y_q;

endmodule

`default_nettype wire

//--- interconnect_consts.svh
`ifndef INTERCONNECT_CONSTS_SVH
`define INTERCONNECT_CONSTS_SVH

// ==============================
// interconnect sizes
// ==============================

// routed message, addr plus data
`define MSG_W 18

// data word and transform sample
`define DATA_W 16

// spi frame, push/pull flags over one message
`define FRAME_W 20

// samples per transform block
`define N_SAMPLES 4

// flops per synchronized spi pin
`define SYNC_DEPTH 2

`endif

//--- interconnect_pkg.sv
`default_nettype none

`include "interconnect_consts.svh"

package interconnect_pkg;

  // ==============================
  // router addresses
  // ==============================
  typedef enum logic [1:0] {
    ROUTE_IN_XBAR  = 2'd0,
    ROUTE_OUT_XBAR = 2'd1,
    ROUTE_IN_CFG   = 2'd2,
    ROUTE_OUT_CFG  = 2'd3
  } route_e;

  // host to device message
  typedef struct packed {
    route_e              addr;
    logic [`DATA_W-1:0]  data;
  } msg_t;

  // device to host response, spare bit is always zero
  typedef struct packed {
    logic                spare;
    logic                src;
    logic [`DATA_W-1:0]  data;
  } resp_t;

  // crossbar route, one input and one output select
  typedef struct packed {
    logic in_sel;
    logic out_sel;
  } xbar_cfg_t;

endpackage

`default_nettype wire

//--- interconnect_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module interconnect_tb;
  import interconnect_pkg::*;

  // ==============================
  // sizes and limits
  // ==============================
  localparam int    HALF_SCLK  = 4;
  localparam int    MAX_FRAMES = 200;
  localparam int    N_ROWS     = 40;
  localparam int    CLK_NS     = 4;
  // full frame budget for every row plus margin
  localparam longint WATCHDOG_NS =
    longint'(N_ROWS) * MAX_FRAMES * `FRAME_W * 2 * HALF_SCLK * CLK_NS + 100_000;

  typedef enum logic [2:0] {K_RESET, K_PUSH, K_CONFIG, K_DRAIN, K_BP_CHECK} kind_e;

  logic        clk;
  logic        rst;
  logic        cs;
  logic        sclk;
  logic        mosi;
  logic        miso;
  logic        minion_parity;
  logic        adapter_parity;
  logic [22:0] io_oeb;
  logic [4:0]  io_out;

  // stimulus table built before reset ends
  string              row_name  [N_ROWS];
  kind_e              row_kind  [N_ROWS];
  route_e             row_route [N_ROWS];
  logic [`DATA_W-1:0] row_data  [N_ROWS];
  resp_t              row_exp   [N_ROWS];
  int                 n_rows;

  resp_t       exp_q [$];
  logic [31:0] lfsr_state;
  logic        bp_seen;

  tb_clock_gen i_clock_gen (
    .clk(clk)
  );

  interconnect_top i_interconnect_top (
    .clk(clk), .rst(rst), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity),
    .io_oeb(io_oeb), .io_out(io_out)
  );

  // ==============================
  // failure and checks
  // ==============================
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input bit expected, input bit actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  task automatic check_parity(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s expected %0b actual %0b", name, expected, actual));
    end
  endtask

  // ==============================
  // reference models
  // ==============================

  // galois form with taps x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  task automatic next_word(output logic [`DATA_W-1:0] w);
    for (int i = 0; i < `DATA_W; i++) begin
      w[i]       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  function automatic resp_t make_resp(input logic src, input logic [`DATA_W-1:0] data);
    resp_t r;
    r.spare = 1'b0;
    r.src   = src;
    r.data  = data;
    return r;
  endfunction

  // natural-order hadamard row k negates sample j when k&j has odd weight
  function automatic logic [`DATA_W-1:0] hadamard_sample(input int k,
                                                         input logic [`DATA_W-1:0] a,
                                                         input logic [`DATA_W-1:0] b,
                                                         input logic [`DATA_W-1:0] c,
                                                         input logic [`DATA_W-1:0] d);
    logic [`DATA_W-1:0] x [`N_SAMPLES];
    logic [`DATA_W-1:0] acc;
    x[0] = a;
    x[1] = b;
    x[2] = c;
    x[3] = d;
    acc  = '0;
    // accumulator width gives the 16-bit wrap
    for (int j = 0; j < `N_SAMPLES; j++) begin
      if (^(k & j)) begin
        acc = acc - x[j];
      end else begin
        acc = acc + x[j];
      end
    end
    return acc;
  endfunction

  // ==============================
  // table construction
  // ==============================
  task automatic add_row(input string name, input kind_e kind, input route_e route,
                         input logic [`DATA_W-1:0] data, input resp_t exp);
    row_name[n_rows]  = name;
    row_kind[n_rows]  = kind;
    row_route[n_rows] = route;
    row_data[n_rows]  = data;
    row_exp[n_rows]   = exp;
    n_rows++;
  endtask

  task automatic build_table();
    logic [`DATA_W-1:0] w;
    logic [`DATA_W-1:0] s [`N_SAMPLES];
    add_row("reset frame", K_RESET, ROUTE_IN_XBAR, '0, '0);
    // loopback under default routes
    for (int i = 0; i < 3; i++) begin
      next_word(w);
      add_row($sformatf("loopback %0d", i), K_PUSH, ROUTE_IN_XBAR, w, make_resp(1'b0, w));
    end
    add_row("loopback drain", K_DRAIN, ROUTE_IN_XBAR, '0, '0);
    // output crossbar into arbiter input 1
    for (int i = 0; i < 3; i++) begin
      next_word(w);
      add_row($sformatf("out xbar %0d", i), K_PUSH, ROUTE_OUT_XBAR, w, make_resp(1'b1, w));
    end
    add_row("out xbar drain", K_DRAIN, ROUTE_IN_XBAR, '0, '0);
    // more words than the path holds
    for (int i = 0; i < 6; i++) begin
      next_word(w);
      add_row($sformatf("flood %0d", i), K_PUSH, ROUTE_IN_XBAR, w, make_resp(1'b0, w));
    end
    add_row("flood drain", K_DRAIN, ROUTE_IN_XBAR, '0, '0);
    add_row("flood space refused", K_BP_CHECK, ROUTE_IN_XBAR, '0, '0);
    // cfg data bit 1 is in_sel and bit 0 is out_sel
    add_row("in xbar to transform", K_CONFIG, ROUTE_IN_CFG, 16'h0001, '0);
    add_row("out xbar from transform", K_CONFIG, ROUTE_OUT_CFG, 16'h0002, '0);
    for (int blk = 0; blk < 2; blk++) begin
      for (int k = 0; k < `N_SAMPLES; k++) begin
        next_word(s[k]);
      end
      for (int k = 0; k < `N_SAMPLES; k++) begin
        add_row($sformatf("transform block %0d sample %0d", blk, k), K_PUSH,
                ROUTE_IN_XBAR, s[k],
                make_resp(1'b1, hadamard_sample(k, s[0], s[1], s[2], s[3])));
      end
    end
    add_row("transform drain", K_DRAIN, ROUTE_IN_XBAR, '0, '0);
    add_row("in xbar back to loopback", K_CONFIG, ROUTE_IN_CFG, 16'h0000, '0);
    for (int i = 0; i < 3; i++) begin
      next_word(w);
      add_row($sformatf("loopback again %0d", i), K_PUSH, ROUTE_IN_XBAR, w,
              make_resp(1'b0, w));
    end
    add_row("loopback again drain", K_DRAIN, ROUTE_IN_XBAR, '0, '0);
  endtask

  // ==============================
  // spi host
  // ==============================
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  // mode 0 msb first with miso sampled just before each rising sclk
  task automatic drive_frame(input logic [`FRAME_W-1:0] tx, output logic [`FRAME_W-1:0] rx);
    cs   = 1'b0;
    sclk = 1'b0;
    mosi = tx[`FRAME_W-1];
    wait_cycles(2 * HALF_SCLK);
    for (int i = `FRAME_W - 1; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(HALF_SCLK);
      rx[i] = miso;
      sclk  = 1'b1;
      wait_cycles(HALF_SCLK);
      sclk = 1'b0;
    end
    wait_cycles(HALF_SCLK);
    cs = 1'b1;
    // frame end handling settles inside this gap
    wait_cycles(2 * HALF_SCLK);
  endtask

  task automatic take_resp(input string name, input resp_t actual);
    resp_t expected;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("%s: response %h arrived when none was expected", name, actual));
    end
    expected = exp_q.pop_front();
    check_resp(name, expected, actual);
    check_parity($sformatf("%s adapter parity", name), ^expected, adapter_parity);
  endtask

  // first try without pull and retries also pull to free the path
  task automatic push_word(input string name, input route_e route,
                           input logic [`DATA_W-1:0] data);
    msg_t                msg;
    logic [`FRAME_W-1:0] rx;
    logic                pull;
    logic                accepted;
    int                  tries;
    msg.addr = route;
    msg.data = data;
    pull     = 1'b0;
    accepted = 1'b0;
    tries    = 0;
    while (!accepted) begin
      if (tries == MAX_FRAMES) begin
        abort_run($sformatf("%s: push refused for %0d frames", name, MAX_FRAMES));
      end
      drive_frame({1'b1, pull, msg}, rx);
      if (pull && rx[`FRAME_W-1]) begin
        take_resp(name, resp_t'(rx[`MSG_W-1:0]));
      end
      // space bit tells whether this frame's push went in
      if (rx[`FRAME_W-2]) begin
        accepted = 1'b1;
      end else begin
        bp_seen = 1'b1;
      end
      pull = 1'b1;
      tries++;
    end
    check_parity($sformatf("%s minion parity", name), ^msg, minion_parity);
  endtask

  task automatic drain_responses(input string name);
    logic [`FRAME_W-1:0] rx;
    int                  idle;
    idle = 0;
    while (exp_q.size() > 0) begin
      if (idle == MAX_FRAMES) begin
        abort_run($sformatf("%s: no response after %0d pull frames", name, MAX_FRAMES));
      end
      drive_frame({2'b01, {`MSG_W{1'b0}}}, rx);
      if (rx[`FRAME_W-1]) begin
        take_resp(name, resp_t'(rx[`MSG_W-1:0]));
        idle = 0;
      end else begin
        idle++;
      end
    end
    // nothing may trail the last expected word
    drive_frame({2'b01, {`MSG_W{1'b0}}}, rx);
    check_flag($sformatf("%s leftover response", name), 1'b0, rx[`FRAME_W-1]);
  endtask

  task automatic check_reset_state(input string name);
    logic [`FRAME_W-1:0] rx;
    check_flag($sformatf("%s miso idle", name), 1'b0, miso);
    check_flag($sformatf("%s io_oeb zero", name), 1'b1, io_oeb == '0);
    check_flag($sformatf("%s io_out zero", name), 1'b1, io_out == '0);
    // empty frame with neither push nor pull
    drive_frame({`FRAME_W{1'b0}}, rx);
    check_flag($sformatf("%s resp_valid", name), 1'b0, rx[`FRAME_W-1]);
    check_flag($sformatf("%s space", name), 1'b1, rx[`FRAME_W-2]);
    check_parity($sformatf("%s minion parity", name), 1'b0, minion_parity);
    check_parity($sformatf("%s adapter parity", name), 1'b0, adapter_parity);
  endtask

  task automatic run_row(input int r);
    case (row_kind[r])
      K_RESET: check_reset_state(row_name[r]);
      K_PUSH: begin
        exp_q.push_back(row_exp[r]);
        push_word(row_name[r], row_route[r], row_data[r]);
      end
      K_CONFIG: push_word(row_name[r], row_route[r], row_data[r]);
      K_DRAIN: drain_responses(row_name[r]);
      K_BP_CHECK: check_flag(row_name[r], 1'b1, bp_seen);
      default: abort_run($sformatf("row %0d has an unknown kind", r));
    endcase
  endtask

  // ==============================
  // main sequence and watchdog
  // ==============================
  initial begin
    rst        = 1'b1;
    cs         = 1'b1;
    sclk       = 1'b0;
    mosi       = 1'b0;
    lfsr_state = 32'h7d96;
    n_rows     = 0;
    bp_seen    = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    wait_cycles(4);
    for (int r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("All tests passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the table finished");
  end

endmodule

`default_nettype wire

//--- interconnect_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module interconnect_top (
  input  logic        clk,
  input  logic        rst,
  input  logic        cs,
  input  logic        sclk,
  input  logic        mosi,
  output logic        miso,
  output logic        minion_parity,
  output logic        adapter_parity,
  output logic [22:0] io_oeb,
  output logic [4:0]  io_out
);
  import interconnect_pkg::*;

  // gpios unused beyond spi
  assign io_oeb = '0;
  assign io_out = '0;

  // ==============================
  // spi and router
  // ==============================
  logic               push_val;
  logic               push_rdy;
  msg_t               push_msg;
  logic               pull_val;
  logic               pull_rdy;
  resp_t              pull_msg;
  logic               rt_val  [4];
  logic               rt_rdy  [4];
  logic [`DATA_W-1:0] rt_data [4];

  spi_minion i_spi_minion (
    .clk(clk), .rst(rst), .cs(cs), .sclk(sclk), .mosi(mosi), .miso(miso),
    .minion_parity(minion_parity), .adapter_parity(adapter_parity),
    .push_val(push_val), .push_msg(push_msg), .push_rdy(push_rdy),
    .pull_val(pull_val), .pull_msg(pull_msg), .pull_rdy(pull_rdy)
  );

  packet_router i_packet_router (
    .clk(clk), .rst(rst),
    .in_val(push_val), .in_rdy(push_rdy), .in_msg(push_msg),
    .out_val(rt_val), .out_rdy(rt_rdy), .out_data(rt_data)
  );

  // ==============================
  // input crossbar
  // ==============================
  logic               ixb_in_val   [2];
  logic               ixb_in_rdy   [2];
  logic [`DATA_W-1:0] ixb_in_data  [2];
  logic               ixb_out_val  [2];
  logic               ixb_out_rdy  [2];
  logic [`DATA_W-1:0] ixb_out_data [2];

  // input 0 from router addr 0, input 1 idle
  assign ixb_in_val[0]  = rt_val[0];
  assign ixb_in_data[0] = rt_data[0];
  assign rt_rdy[0]      = ixb_in_rdy[0];
  assign ixb_in_val[1]  = 1'b0;
  assign ixb_in_data[1] = '0;

  blocking_crossbar i_in_xbar (
    .clk(clk), .rst(rst),
    .in_val(ixb_in_val), .in_rdy(ixb_in_rdy), .in_data(ixb_in_data),
    .out_val(ixb_out_val), .out_rdy(ixb_out_rdy), .out_data(ixb_out_data),
    .ctl_val(rt_val[2]), .ctl_rdy(rt_rdy[2]), .ctl_cfg(xbar_cfg_t'(rt_data[2][1:0]))
  );

  // ==============================
  // transform path
  // ==============================
  logic               des_val;
  logic               des_rdy;
  logic [`DATA_W-1:0] des_block [`N_SAMPLES];
  logic               wht_val;
  logic               wht_rdy;
  logic [`DATA_W-1:0] wht_block [`N_SAMPLES];
  logic               oxb_in_val   [2];
  logic               oxb_in_rdy   [2];
  logic [`DATA_W-1:0] oxb_in_data  [2];

  sample_deserializer i_deserializer (
    .clk(clk), .rst(rst),
    .in_val(ixb_out_val[1]), .in_rdy(ixb_out_rdy[1]), .in_data(ixb_out_data[1]),
    .out_val(des_val), .out_rdy(des_rdy), .out_block(des_block)
  );

  hadamard_transform i_hadamard (
    .clk(clk), .rst(rst),
    .in_val(des_val), .in_rdy(des_rdy), .in_block(des_block),
    .out_val(wht_val), .out_rdy(wht_rdy), .out_block(wht_block)
  );

  sample_serializer i_serializer (
    .clk(clk), .rst(rst),
    .in_val(wht_val), .in_rdy(wht_rdy), .in_block(wht_block),
    .out_val(oxb_in_val[1]), .out_rdy(oxb_in_rdy[1]), .out_data(oxb_in_data[1])
  );

  // ==============================
  // output crossbar and arbiter
  // ==============================
  logic               oxb_out_val  [2];
  logic               oxb_out_rdy  [2];
  logic [`DATA_W-1:0] oxb_out_data [2];
  logic               arb_val  [2];
  logic               arb_rdy  [2];
  logic [`DATA_W-1:0] arb_data [2];

  // input 0 from router addr 1
  assign oxb_in_val[0]  = rt_val[1];
  assign oxb_in_data[0] = rt_data[1];
  assign rt_rdy[1]      = oxb_in_rdy[0];
  // output 1 has no sink
  assign oxb_out_rdy[1] = 1'b0;

  blocking_crossbar i_out_xbar (
    .clk(clk), .rst(rst),
    .in_val(oxb_in_val), .in_rdy(oxb_in_rdy), .in_data(oxb_in_data),
    .out_val(oxb_out_val), .out_rdy(oxb_out_rdy), .out_data(oxb_out_data),
    .ctl_val(rt_val[3]), .ctl_rdy(rt_rdy[3]), .ctl_cfg(xbar_cfg_t'(rt_data[3][1:0]))
  );

  // arbiter 0 is the loopback, 1 the output crossbar
  assign arb_val[0]     = ixb_out_val[0];
  assign arb_data[0]    = ixb_out_data[0];
  assign ixb_out_rdy[0] = arb_rdy[0];
  assign arb_val[1]     = oxb_out_val[0];
  assign arb_data[1]    = oxb_out_data[0];
  assign oxb_out_rdy[0] = arb_rdy[1];

  stream_arbiter i_arbiter (
    .clk(clk), .rst(rst),
    .in_val(arb_val), .in_rdy(arb_rdy), .in_data(arb_data),
    .out_val(pull_val), .out_rdy(pull_rdy), .out_msg(pull_msg)
  );

endmodule

`default_nettype wire

//--- packet_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module packet_router (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_val,
  output logic                   in_rdy,
  input  interconnect_pkg::msg_t in_msg,
  output logic                   out_val  [4],
  input  logic                   out_rdy  [4],
  output logic [`DATA_W-1:0]     out_data [4]
);
  import interconnect_pkg::*;

  logic               full_q;
  route_e             addr_q;
  logic [`DATA_W-1:0] data_q;
  logic               drain;

  // register drains when its chosen output takes it
  assign drain  = full_q & out_rdy[addr_q];
  assign in_rdy = ~full_q | drain;

  always_ff @(posedge clk) begin
    if (rst) begin
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      full_q <= 1'b1;
    end else if (drain) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      addr_q <= in_msg.addr;
      data_q <= in_msg.data;
    end
  end

  // address stripped, only one val up
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      out_val[i]  = full_q && (addr_q == route_e'(i));
      out_data[i] = data_q;
    end
  end

endmodule

`default_nettype wire

//--- sample_deserializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module sample_deserializer (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_val,
  output logic               in_rdy,
  input  logic [`DATA_W-1:0] in_data,
  output logic               out_val,
  input  logic               out_rdy,
  output logic [`DATA_W-1:0] out_block [`N_SAMPLES]
);

  localparam int CNT_W = $clog2(`N_SAMPLES);

  logic [CNT_W-1:0]   cnt_q;
  logic               full_q;
  logic [`DATA_W-1:0] block_q [`N_SAMPLES];

  // no new samples while a block waits
  assign in_rdy = ~full_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      if (cnt_q == CNT_W'(`N_SAMPLES - 1)) begin
        cnt_q  <= '0;
        full_q <= 1'b1;
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end else if (full_q && out_rdy) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      block_q[cnt_q] <= in_data;
    end
  end

  assign out_val   = full_q;
  assign out_block = block_q;

endmodule

`default_nettype wire

//--- sample_serializer.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module sample_serializer (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_val,
  output logic               in_rdy,
  input  logic [`DATA_W-1:0] in_block [`N_SAMPLES],
  output logic               out_val,
  input  logic               out_rdy,
  output logic [`DATA_W-1:0] out_data
);

  localparam int IDX_W = $clog2(`N_SAMPLES);

  logic [IDX_W-1:0]   idx_q;
  logic               full_q;
  logic [`DATA_W-1:0] block_q [`N_SAMPLES];

  // next block only once the last sample left
  assign in_rdy = ~full_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      idx_q  <= '0;
      full_q <= 1'b0;
    end else if (in_val && in_rdy) begin
      full_q <= 1'b1;
    end else if (full_q && out_rdy) begin
      if (idx_q == IDX_W'(`N_SAMPLES - 1)) begin
        idx_q  <= '0;
        full_q <= 1'b0;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      block_q <= in_block;
    end
  end

  // sample 0 goes out first
  assign out_val  = full_q;
  assign out_data = block_q[idx_q];

endmodule

`default_nettype wire

//--- spi_minion.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module spi_minion (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    cs,
  input  logic                    sclk,
  input  logic                    mosi,
  output logic                    miso,
  output logic                    minion_parity,
  output logic                    adapter_parity,
  output logic                    push_val,
  output interconnect_pkg::msg_t  push_msg,
  input  logic                    push_rdy,
  input  logic                    pull_val,
  input  interconnect_pkg::resp_t pull_msg,
  output logic                    pull_rdy
);
  import interconnect_pkg::*;

  localparam int TOP = `SYNC_DEPTH - 1;

  // ==============================
  // pin synchronizers
  // ==============================
  logic [`SYNC_DEPTH-1:0] sclk_sync;
  logic [`SYNC_DEPTH-1:0] cs_sync;
  logic [`SYNC_DEPTH-1:0] mosi_sync;
  logic                   sclk_q;
  logic                   cs_q;
  logic                   sclk_rise;
  logic                   sclk_fall;
  logic                   cs_fall;
  logic                   cs_rise;

  always_ff @(posedge clk) begin
    if (rst) begin
      sclk_sync <= '0;
      // cs idles high
      cs_sync   <= '1;
      sclk_q    <= 1'b0;
      cs_q      <= 1'b1;
    end else begin
      sclk_sync <= {sclk_sync[TOP-1:0], sclk};
      cs_sync   <= {cs_sync[TOP-1:0], cs};
      sclk_q    <= sclk_sync[TOP];
      cs_q      <= cs_sync[TOP];
    end
  end

  always_ff @(posedge clk) begin
    mosi_sync <= {mosi_sync[TOP-1:0], mosi};
  end

  // sclk edges only count inside a frame
  assign sclk_rise = ~cs_sync[TOP] & sclk_sync[TOP] & ~sclk_q;
  assign sclk_fall = ~cs_sync[TOP] & ~sclk_sync[TOP] & sclk_q;
  assign cs_fall   = ~cs_sync[TOP] & cs_q;
  assign cs_rise   = cs_sync[TOP] & ~cs_q;

  // ==============================
  // frame shifter and buffers
  // ==============================
  logic [`FRAME_W-1:0] shreg;
  logic                miso_q;
  logic                space_q;
  logic                rv_q;
  logic                push_full;
  msg_t                push_q;
  logic                resp_full;
  resp_t               resp_q;
  logic                push_bit;
  logic                pull_bit;

  assign push_bit = shreg[`FRAME_W-1];
  assign pull_bit = shreg[`FRAME_W-2];

  always_ff @(posedge clk) begin
    if (rst) begin
      miso_q         <= 1'b0;
      space_q        <= 1'b0;
      rv_q           <= 1'b0;
      push_full      <= 1'b0;
      resp_full      <= 1'b0;
      minion_parity  <= 1'b0;
      adapter_parity <= 1'b0;
    end else begin
      if (push_full && push_rdy) begin
        push_full <= 1'b0;
      end
      // refill response whenever empty
      if (!resp_full && pull_val) begin
        resp_full <= 1'b1;
      end
      if (cs_fall) begin
        rv_q    <= resp_full;
        space_q <= ~push_full;
        miso_q  <= resp_full;
      end else if (sclk_fall) begin
        miso_q <= shreg[`FRAME_W-1];
      end
      if (cs_rise) begin
        miso_q <= 1'b0;
        // push only if space was offered at frame start
        if (push_bit && space_q) begin
          push_full     <= 1'b1;
          minion_parity <= ^shreg[`MSG_W-1:0];
        end
        // consume only what was shown as valid
        if (pull_bit && rv_q) begin
          resp_full      <= 1'b0;
          adapter_parity <= ^resp_q;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cs_fall) begin
      shreg <= {resp_full, ~push_full, (resp_full ? resp_q : resp_t'('0))};
    end else if (sclk_rise) begin
      shreg <= {shreg[`FRAME_W-2:0], mosi_sync[TOP]};
    end
    if (cs_rise && push_bit && space_q) begin
      push_q <= msg_t'(shreg[`MSG_W-1:0]);
    end
    if (!resp_full && pull_val) begin
      resp_q <= pull_msg;
    end
  end

  assign miso     = miso_q;
  assign push_val = push_full;
  assign push_msg = push_q;
  assign pull_rdy = ~resp_full;

endmodule

`default_nettype wire

//--- stream_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "interconnect_consts.svh"

module stream_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    in_val  [2],
  output logic                    in_rdy  [2],
  input  logic [`DATA_W-1:0]      in_data [2],
  output logic                    out_val,
  input  logic                    out_rdy,
  output interconnect_pkg::resp_t out_msg
);
  import interconnect_pkg::*;

  logic  ptr_q;
  logic  full_q;
  resp_t out_q;
  logic  take;
  logic  grant_val;
  logic  grant;

  // output register free or draining
  assign take = ~full_q | out_rdy;

  // pointer input has priority this round
  always_comb begin
    grant_val = in_val[0] | in_val[1];
    grant     = in_val[ptr_q] ? ptr_q : ~ptr_q;
    for (int i = 0; i < 2; i++) begin
      in_rdy[i] = take && grant_val && (grant == 1'(i));
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q  <= 1'b0;
      full_q <= 1'b0;
    end else if (take) begin
      full_q <= grant_val;
      // move past the winner
      if (grant_val) begin
        ptr_q <= ~grant;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && grant_val) begin
      out_q <= '{spare: 1'b0, src: grant, data: in_data[grant]};
    end
  end

  assign out_val = full_q;
  assign out_msg = out_q;

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk
);

  // half of the 4 ns period
  localparam int HALF_PERIOD_NS = 2;

  initial begin
    clk = 1'b0;
  end

  always begin
    #(HALF_PERIOD_NS) clk = ~clk;
  end

endmodule

`default_nettype wire
